/* Makefile */
VERILATOR ?= verilator
TOP       ?= fetch_frontend_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
riscv_pkg.sv
fetch_pkg.sv
fetch_stage1.sv
imem.sv
fetch_stage2.sv
fetch_control.sv
fetch_frontend.sv
tb_clock_gen.sv
fetch_frontend_tb.sv

/* fetch_control.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_control (
    // Downstream handshake as seen at stage 2
    input  logic            out_valid,
    input  logic            out_ready,

    // Internal redirect from the JAL predecode
    input  logic            jal_taken,
    input  riscv_pkg::pc_t  jal_target,

    // External redirect, e.g. branch or exception from a back end
    input  logic            redirect_en,
    input  riscv_pkg::pc_t  redirect_pc,

    output logic            f1_stall,
    output logic            f1_flush,
    output logic            f2_flush,
    output logic            pc_load_en,
    output riscv_pkg::pc_t  pc_load_val
);

    always_comb begin
        f1_flush    = 1'b0;
        f2_flush    = 1'b0;
        pc_load_en  = 1'b0;
        pc_load_val = jal_target;
        // External redirect takes priority and kills both stages
        if (redirect_en) begin
            pc_load_en  = 1'b1;
            pc_load_val = redirect_pc;
            f1_flush    = 1'b1;
            f2_flush    = 1'b1;
        end else if (jal_taken) begin
            // Stage 2 empties itself as the JAL leaves
            pc_load_en = 1'b1;
            f1_flush   = 1'b1;
        end
    end

    // Held but not accepted, unless a flush overrides it
    assign f1_stall = out_valid && !out_ready && !f1_flush;

endmodule : fetch_control

`default_nettype wire

/* fetch_frontend.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend (
    input  logic              clk,
    input  logic              rst_n,

    // Redirect from the back end
    input  logic              redirect_en,
    input  riscv_pkg::pc_t    redirect_pc,

    // Instruction stream out
    input  logic              out_ready,
    output logic              out_valid,
    output riscv_pkg::pc_t    out_pc,
    output riscv_pkg::word_t  out_instr
);

    import riscv_pkg::*;

    logic  fetch_en;
    pc_t   fetch_addr;
    word_t rdata;
    logic  f1_valid;
    pc_t   f1_pc;
    logic  f1_stall;
    logic  f1_flush;
    logic  f2_flush;
    logic  pc_load_en;
    pc_t   pc_load_val;
    logic  jal_taken;
    pc_t   jal_target;

    // PC generation and ROM request
    fetch_stage1 u_stage1 (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc_load_en  (pc_load_en),
        .pc_load_val (pc_load_val),
        .f1_stall    (f1_stall),
        .f1_flush    (f1_flush),
        .fetch_en    (fetch_en),
        .fetch_addr  (fetch_addr),
        .f1_valid    (f1_valid),
        .f1_pc       (f1_pc)
    );

    imem u_imem (
        .clk        (clk),
        .fetch_en   (fetch_en),
        .fetch_addr (fetch_addr),
        .rdata      (rdata)
    );

    // Output register and JAL predecode
    fetch_stage2 u_stage2 (
        .clk        (clk),
        .rst_n      (rst_n),
        .f1_valid   (f1_valid),
        .f1_pc      (f1_pc),
        .rdata      (rdata),
        .f2_flush   (f2_flush),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_pc     (out_pc),
        .out_instr  (out_instr),
        .jal_taken  (jal_taken),
        .jal_target (jal_target)
    );

    // Stall, flush and PC load
    fetch_control u_control (
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .jal_taken   (jal_taken),
        .jal_target  (jal_target),
        .redirect_en (redirect_en),
        .redirect_pc (redirect_pc),
        .f1_stall    (f1_stall),
        .f1_flush    (f1_flush),
        .f2_flush    (f2_flush),
        .pc_load_en  (pc_load_en),
        .pc_load_val (pc_load_val)
    );

endmodule : fetch_frontend

`default_nettype wire

/* fetch_frontend_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend_tb;

    import riscv_pkg::*;
    import fetch_pkg::*;

    logic  clk;
    logic  rst_n;
    logic  redirect_en;
    pc_t   redirect_pc;
    logic  out_ready;
    logic  out_valid;
    pc_t   out_pc;
    word_t out_instr;

    int    seed;
    int    mismatches;
    int    failures;
    int    transfers;
    int    jal_fwd;
    int    jal_bwd;
    pc_t   exp_pc;
    logic  held;
    logic  held_redir;
    pc_t   held_pc;
    word_t held_instr;
    word_t ref_mem [IMEM_WORDS];

    tb_clock_gen clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fetch_frontend DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .redirect_en (redirect_en),
        .redirect_pc (redirect_pc),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_pc      (out_pc),
        .out_instr   (out_instr)
    );

    // Program word at a byte address with the image repeating every 64 words
    function automatic word_t rom_word(input pc_t pc);
        return ref_mem[pc[IMEM_ADDR_BITS+1:2]];
    endfunction

    // Next PC in program order
    function automatic pc_t expected_next(input pc_t pc);
        word_t w;
        pc_t   imm;
        w = rom_word(pc);
        if (w[6:0] == OPCODE_JAL) begin
            // J-immediate from its ISA bit positions
            imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            return pc + imm;
        end
        return pc + 32'd4;
    endfunction

    // Outputs are read at the falling edge before the edge that transfers
    task automatic sample_outputs(output logic xfer);
        pc_t   target;
        word_t w;
        // A held entry stays put unless a redirect flushed it
        if (held && !held_redir) begin
            assert (out_valid && out_pc == held_pc && out_instr == held_instr) else begin
                $display("MISMATCH at %0t: held pc %h instr %h, got valid %b pc %h instr %h",
                         $time, held_pc, held_instr, out_valid, out_pc, out_instr);
                mismatches++;
            end
        end
        xfer = out_valid && out_ready;
        if (xfer) begin
            w = rom_word(exp_pc);
            target = expected_next(exp_pc);
            assert (out_pc == exp_pc) else begin
                $display("MISMATCH at %0t: pc expected %h, got %h", $time, exp_pc, out_pc);
                mismatches++;
            end
            assert (out_instr == w) else begin
                $display("MISMATCH at %0t: instr at %h expected %h, got %h",
                         $time, exp_pc, w, out_instr);
                mismatches++;
            end
            if (w[6:0] == OPCODE_JAL) begin
                if (target > exp_pc) begin
                    jal_fwd++;
                end else begin
                    jal_bwd++;
                end
            end
            transfers++;
            exp_pc = target;
        end
        // Stream restarts at the redirect target
        if (redirect_en) begin
            exp_pc = redirect_pc;
        end
        held       = out_valid && !out_ready;
        held_redir = redirect_en;
        held_pc    = out_pc;
        held_instr = out_instr;
    endtask

    // One clock cycle of stimulus followed by the output check
    task automatic drive_cycle(input logic ready, input logic redir, input pc_t rpc,
                               output logic xfer);
        @(posedge clk);
        out_ready   <= ready;
        redirect_en <= redir;
        redirect_pc <= rpc;
        @(negedge clk);
        sample_outputs(xfer);
    endtask

    task automatic run_transfers(input int count, input logic random_ready);
        int   seen;
        int   cycles;
        int   r;
        logic ready;
        logic xfer;
        seen   = 0;
        cycles = 0;
        while (seen < count && cycles < count * 8 + 20) begin
            r     = $random(seed);
            ready = random_ready ? r[0] : 1'b1;
            drive_cycle(ready, 1'b0, '0, xfer);
            if (xfer) begin
                seen++;
            end
            cycles++;
        end
        if (seen < count) begin
            $display("Timeout at %0t: only %0d of %0d transfers arrived", $time, seen, count);
            failures++;
        end
    endtask

    task automatic reset_release();
        int   waited;
        int   steps;
        logic xfer;
        waited = 0;
        steps  = 0;
        xfer   = 1'b0;
        while (rst_n !== 1'b1 && waited < 50) begin
            // Only look after a real clock edge has applied the reset
            @(posedge clk);
            @(negedge clk);
            if (rst_n !== 1'b1) begin
                assert (out_valid === 1'b0) else begin
                    $display("MISMATCH at %0t: out_valid %b in reset", $time, out_valid);
                    mismatches++;
                end
            end
            waited++;
        end
        while (rst_n === 1'b1 && !xfer && steps < 10) begin
            drive_cycle(1'b1, 1'b0, '0, xfer);
            steps++;
        end
        if (!xfer) begin
            $display("Timeout at %0t: no first transfer after reset", $time);
            failures++;
        end else begin
            // Transfer edge counted from the edge that released reset
            assert (steps + 1 == 3) else begin
                $display("MISMATCH at %0t: first transfer on edge %0d, expected edge 3",
                         $time, steps + 1);
                mismatches++;
            end
        end
    endtask

    // Words 1 to 7 hold no JAL
    task automatic straight_line_stream();
        run_transfers(7, 1'b0);
    endtask

    task automatic back_pressure_stream();
        run_transfers(60, 1'b1);
    endtask

    task automatic jal_redirects();
        int fwd_before;
        int bwd_before;
        fwd_before = jal_fwd;
        bwd_before = jal_bwd;
        run_transfers(30, 1'b0);
        assert (jal_fwd > fwd_before && jal_bwd > bwd_before) else begin
            $display("Forward and backward JALs were not both delivered in the JAL test");
            failures++;
        end
    endtask

    task automatic external_redirects();
        int   i;
        int   r;
        logic xfer;
        pc_t  target;
        for (i = 0; i < 12; i++) begin
            r      = $random(seed);
            target = pc_t'(r) & 32'h0000_00FC;
            run_transfers(1 + int'(r[3:0]), 1'b1);
            if (i[0]) begin
                // Stage 2 fills up and stalls before the pulse
                drive_cycle(1'b0, 1'b0, '0, xfer);
                drive_cycle(1'b0, 1'b0, '0, xfer);
                drive_cycle(1'b0, 1'b1, target, xfer);
            end else begin
                drive_cycle(r[8], 1'b1, target, xfer);
            end
            run_transfers(4, 1'b1);
        end
    endtask

    initial begin
        seed        = 32'h938d_9a86;
        mismatches  = 0;
        failures    = 0;
        transfers   = 0;
        jal_fwd     = 0;
        jal_bwd     = 0;
        exp_pc      = RESET_PC;
        held        = 1'b0;
        held_redir  = 1'b0;
        held_pc     = '0;
        held_instr  = '0;
        out_ready   = 1'b1;
        redirect_en = 1'b0;
        redirect_pc = '0;
        $readmemh("imem.hex", ref_mem);
        reset_release();
        straight_line_stream();
        back_pressure_stream();
        jal_redirects();
        external_redirects();
        $display("Checked %0d transfers, %0d mismatches, %0d other failures",
                 transfers, mismatches, failures);
        if (mismatches == 0 && failures == 0 && transfers > 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule : fetch_frontend_tb

`default_nettype wire

/* fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // First fetch address after reset
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // Word index width into the ROM, 64 words
    localparam int IMEM_ADDR_BITS = 6;
    localparam int IMEM_WORDS     = 1 << IMEM_ADDR_BITS;

endpackage : fetch_pkg

`default_nettype wire

/* fetch_stage1.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage1 (
    input  logic            clk,
    input  logic            rst_n,

    // PC load from control on a redirect
    input  logic            pc_load_en,
    input  riscv_pkg::pc_t  pc_load_val,

    // Hazard controls from control
    input  logic            f1_stall,
    input  logic            f1_flush,

    // Request to the instruction ROM
    output logic            fetch_en,
    output riscv_pkg::pc_t  fetch_addr,

    // To stage 2
    output logic            f1_valid,
    output riscv_pkg::pc_t  f1_pc
);

    import riscv_pkg::*;
    import fetch_pkg::*;

    logic init;
    pc_t  pc_q;
    pc_t  next_pc;

    // Init lasts one unstalled cycle so RESET_PC can reach the ROM first
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            init <= 1'b1;
        end else if (!f1_stall) begin
            init <= 1'b0;
        end
    end

    // Redirect target wins over the sequential address
    always_comb begin
        if (pc_load_en) begin
            next_pc = pc_load_val;
        end else begin
            next_pc = pc_q + 32'd4;
        end
    end

    // PC moves together with the ROM address register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= RESET_PC;
        end else if (!f1_stall && !init) begin
            pc_q <= next_pc;
        end
    end

    // While stalled or in init the ROM must keep pointing at the current PC
    assign fetch_addr = (f1_stall || init) ? pc_q : next_pc;

    // Flush still writes the ROM address, so the new target gets fetched
    assign fetch_en = !f1_stall;

    assign f1_valid = !init && !f1_flush && !f1_stall;
    assign f1_pc    = pc_q;

endmodule : fetch_stage1

`default_nettype wire

/* fetch_stage2.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_stage2 (
    input  logic              clk,
    input  logic              rst_n,

    // From stage 1 and the ROM, aligned in the same cycle
    input  logic              f1_valid,
    input  riscv_pkg::pc_t    f1_pc,
    input  riscv_pkg::word_t  rdata,

    // Drops the held instruction on an external redirect
    input  logic              f2_flush,

    // Downstream valid/ready
    input  logic              out_ready,
    output logic              out_valid,
    output riscv_pkg::pc_t    out_pc,
    output riscv_pkg::word_t  out_instr,

    // Redirect request for a JAL leaving this stage
    output logic              jal_taken,
    output riscv_pkg::pc_t    jal_target
);

    import riscv_pkg::*;

    instr_u instr_q;
    pc_t    jal_imm;
    logic   accept;
    logic   load;
    logic   jal_match;

    assign accept = out_valid && out_ready;

    // New entry only when the slot frees up this edge
    assign load = f1_valid && (!out_valid || out_ready);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (f2_flush) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (accept) begin
            out_valid <= 1'b0;
        end
    end

    // Payload held steady under back-pressure
    always_ff @(posedge clk) begin
        if (load) begin
            out_pc      <= f1_pc;
            instr_q.raw <= rdata;
        end
    end

    assign out_instr = instr_q.raw;

    // J-type immediate, sign bit is imm[20]
    assign jal_imm = {{11{instr_q.j.imm_20}}, instr_q.j.imm_20, instr_q.j.imm_19_12,
                      instr_q.j.imm_11, instr_q.j.imm_10_1, 1'b0};

    assign jal_match  = out_valid && (instr_q.j.opcode == OPCODE_JAL);
    assign jal_target = out_pc + jal_imm;

    // Redirect only once the JAL actually leaves
    assign jal_taken = jal_match && out_ready;

endmodule : fetch_stage2

`default_nettype wire

/* imem.hex */
// Eight 32-bit instruction words per line, word index = byte address / 4
// Words 0-7 straight code, 8 JAL +32, 16-23 straight code, 24 JAL -80, rest filler
00000013 00100093 00200113 00300193 00400213 00500293 00600313 00700393
0200006F 0BAD0024 0BAD0028 0BAD002C 0BAD0030 0BAD0034 0BAD0038 0BAD003C
00108093 00210113 00318193 00420213 00528293 00630313 00738393 00840413
FB1FF06F 0BAD0064 0BAD0068 0BAD006C 0BAD0070 0BAD0074 0BAD0078 0BAD007C
0BAD0080 0BAD0084 0BAD0088 0BAD008C 0BAD0090 0BAD0094 0BAD0098 0BAD009C
0BAD00A0 0BAD00A4 0BAD00A8 0BAD00AC 0BAD00B0 0BAD00B4 0BAD00B8 0BAD00BC
0BAD00C0 0BAD00C4 0BAD00C8 0BAD00CC 0BAD00D0 0BAD00D4 0BAD00D8 0BAD00DC
0BAD00E0 0BAD00E4 0BAD00E8 0BAD00EC 0BAD00F0 0BAD00F4 0BAD00F8 0BAD00FC

/* imem.sv */
`timescale 1ns/1ps
`default_nettype none

module imem (
    input  logic              clk,

    // Address request from stage 1
    input  logic              fetch_en,
    input  riscv_pkg::pc_t    fetch_addr,

    // Word at the registered address
    output riscv_pkg::word_t  rdata
);

    import riscv_pkg::*;
    import fetch_pkg::*;

    word_t                     mem [IMEM_WORDS];
    logic [IMEM_ADDR_BITS-1:0] addr_q;

    // Program image
    initial begin
        $readmemh("imem.hex", mem);
    end

    // Word index only, upper bits wrap and bits 1:0 are ignored
    always_ff @(posedge clk) begin
        if (fetch_en) begin
            addr_q <= fetch_addr[IMEM_ADDR_BITS+1:2];
        end
    end

    // Read is combinational from the registered index
    assign rdata = mem[addr_q];

endmodule : imem

`default_nettype wire

/* riscv_pkg.sv */
`default_nettype none

package riscv_pkg;

    // Plain 32-bit data or instruction word
    typedef logic [31:0] word_t;

    // Byte address, instructions sit on 4-byte boundaries
    typedef logic [31:0] pc_t;

    // Major opcode of JAL
    localparam logic [6:0] OPCODE_JAL = 7'b1101111;

    // One instruction word seen either raw or split into J-type fields
    typedef union packed {
        word_t raw;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } instr_u;

endpackage : riscv_pkg

`default_nettype wire

/* tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Reset low for five rising edges
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire
